/* files.f */
+incdir+src
src/exPkg.sv
src/operandIssue.sv
src/issueQueue.sv
src/executeStage.sv
src/exSubsystem.sv
tests/exSubsystem_assert.sv
tests/exSubsystemTb.sv

/* run.sh */
#!/bin/sh
# compile and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module exSubsystemTb \
    -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/VexSubsystemTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* tests/exSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module exSubsystemTb
    import exPkg::*;
();

    localparam int NumInstr   = 200;
    localparam int CycleLimit = NumInstr * 40;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    decodedInstr instr;
    logic        instrCredit;
    logic        resValid;
    exResult     result;
    logic        resCredit;

    dataWord refRegs [`NUM_REGS];   // register state as seen in program order
    exResult expected [$];
    int      sent = 0;
    int      creditPulses = 0;
    int      received = 0;
    int      creditsGiven = 0;
    int      cycles = 0;
    int      valueErrors = 0;
    int      protocolErrors = 0;

    exSubsystem dut0 (
        .i_clk         (clk),
        .i_rstN        (rstN),
        .i_instrValid  (instrValid),
        .i_instr       (instr),
        .o_instrCredit (instrCredit),
        .o_resValid    (resValid),
        .o_result      (result),
        .i_resCredit   (resCredit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("timeout: only %0d of %0d results arrived", received, NumInstr);
            $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic dataWord aluModel(aluOp op, dataWord a, dataWord b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return ~(a | b);
        endcase
    endfunction

    function automatic exResult predict(decodedInstr ins);
        exResult r;
        dataWord a;
        dataWord b;
        a = refRegs[ins.rs];  // entry 0 is never written
        b = refRegs[ins.rt];
        r.aluOut      = aluModel(ins.aluOp, a, ins.aluSrcB ? ins.imm : b);
        r.zero        = (r.aluOut == '0);
        r.writeData   = b;
        r.writeReg    = ins.regDst ? ins.rd : ins.rt;
        r.regWrite    = ins.regWrite;
        r.memWrite    = ins.memWrite;
        r.memToReg    = ins.memToReg;
        r.branchReq   = ins.branchReq;
        r.branchTaken = ins.branchReq && r.zero;
        r.branchAddr  = ins.pcPlus4 + (ins.imm & ~32'h3);
        return r;
    endfunction

    // few registers in use so that dependencies come up often
    task automatic randomInstr(output decodedInstr ins, input int n);
        ins.rs        = regIdx'($urandom % 8);
        ins.rt        = regIdx'($urandom % 8);
        ins.rd        = regIdx'($urandom % 8);
        ins.imm       = ($urandom % 4 == 0) ? $urandom : dataWord'(int'($urandom % 64) - 32);
        ins.pcPlus4   = addrWord'(32'h0040_0000 + 4 * (n + 1));
        ins.aluOp     = aluOp'($urandom % 6);
        ins.aluSrcB   = 1'($urandom % 2);
        ins.regDst    = 1'($urandom % 2);
        ins.regWrite  = ($urandom % 4 != 0);
        ins.memWrite  = ($urandom % 4 == 0);
        ins.memToReg  = ($urandom % 5 == 0);
        ins.branchReq = ($urandom % 4 == 0);
    endtask

    task automatic compareField(string name, dataWord got, dataWord want);
        assert (got === want) else begin
            valueErrors++;
            $display("Error: %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic checkResult(exResult got);
        exResult want;
        if (expected.size() == 0) begin
            protocolErrors++;
            $display("a result arrived with no instruction outstanding");
        end else begin
            want = expected.pop_front();
            compareField("aluOut", got.aluOut, want.aluOut);
            compareField("zero", 32'(got.zero), 32'(want.zero));
            compareField("writeData", got.writeData, want.writeData);
            compareField("writeReg", 32'(got.writeReg), 32'(want.writeReg));
            compareField("regWrite", 32'(got.regWrite), 32'(want.regWrite));
            compareField("memWrite", 32'(got.memWrite), 32'(want.memWrite));
            compareField("memToReg", 32'(got.memToReg), 32'(want.memToReg));
            compareField("branchReq", 32'(got.branchReq), 32'(want.branchReq));
            compareField("branchTaken", 32'(got.branchTaken), 32'(want.branchTaken));
            compareField("branchAddr", got.branchAddr, want.branchAddr);
        end
    endtask

    // mid-cycle sampling keeps clear of the edge where outputs change
    always @(negedge clk) begin
        if (rstN) begin
            if (instrCredit) begin
                creditPulses++;
            end
            if (resValid) begin
                received++;
                checkResult(result);
            end
        end
    end

    initial begin
        decodedInstr ins;
        exResult     r;
        logic        slowPhase;
        void'($urandom(32'h739c_9e4c));
        for (int i = 0; i < `NUM_REGS; i++) begin
            refRegs[i] = '0;
        end
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        resCredit  = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        while (sent < NumInstr || received < NumInstr) begin
            @(posedge clk);
            #1;
            instrValid = 1'b0;
            resCredit  = 1'b0;
            if (sent < NumInstr && (`IN_CREDITS + creditPulses - sent) > 0
                    && $urandom % 4 != 0) begin
                randomInstr(ins, sent);
                r = predict(ins);
                if (r.regWrite && !r.memToReg && r.writeReg != '0) begin
                    refRegs[r.writeReg] = r.aluOut;
                end
                expected.push_back(r);
                instr      = ins;
                instrValid = 1'b1;
                sent++;
            end
            slowPhase = ((cycles / 64) % 2) == 1;  // long stretches of scarce credits
            if (received > creditsGiven && $urandom % (slowPhase ? 6 : 2) == 0) begin
                resCredit = 1'b1;
                creditsGiven++;
            end
        end
        repeat (8) @(posedge clk);
        assert (creditPulses == sent) else begin
            protocolErrors++;
            $display("Error: o_instrCredit pulses got %h expected %h", creditPulses, sent);
        end
        assert (expected.size() == 0) else begin
            protocolErrors++;
            $display("some expected results never arrived");
        end
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/exSubsystem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module exSubsystemAssert #(
    parameter int CntW = $clog2(`QUEUE_DEPTH + 1)
) (
    input logic            i_clk,
    input logic            i_rstN,
    input logic            i_push,
    input logic            i_pop,
    input logic [CntW-1:0] i_queueCount,
    input logic [CntW-1:0] i_queueCredits,
    input logic [CntW-1:0] i_outCredits,
    input logic            i_instrCredit,
    input logic            i_instrValid
);

    logic slotFull;  // an accepted instruction whose credit has not come back yet

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            slotFull <= 1'b0;
        end else begin
            slotFull <= i_instrValid || (slotFull && !i_instrCredit);
        end
    end

    pushNotFull: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_push |-> i_queueCount != CntW'(`QUEUE_DEPTH))
        else $error("issue queue pushed while full");

    popNotEmpty: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_pop |-> i_queueCount != '0)
        else $error("issue queue popped while empty");

    // an unsigned counter that wraps below zero also lands above the depth
    queueCreditRange: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_queueCredits <= CntW'(`QUEUE_DEPTH))
        else $error("producer queue credits out of range");

    outCreditRange: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_outCredits <= CntW'(`QUEUE_DEPTH))
        else $error("execute output credits out of range");

    creditNeedsSlot: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_instrCredit |-> slotFull)
        else $error("instruction credit returned with an empty holding slot");

endmodule

bind exSubsystem exSubsystemAssert uAssert (
    .i_clk          (i_clk),
    .i_rstN         (i_rstN),
    .i_push         (push),
    .i_pop          (pop),
    .i_queueCount   (uQueue.count),
    .i_queueCredits (uIssue.queueCredits),
    .i_outCredits   (uExec.outCredits),
    .i_instrCredit  (o_instrCredit),
    .i_instrValid   (i_instrValid)
);

`default_nettype wire

/* src/exSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module exSubsystem
    import exPkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstN,
    input  logic        i_instrValid,
    input  decodedInstr i_instr,
    output logic        o_instrCredit,
    output logic        o_resValid,
    output exResult     o_result,
    input  logic        i_resCredit
);

    logic    push;
    logic    pop;
    logic    queueCredit;
    logic    notEmpty;
    exPacket packet;
    exPacket head;
    wbBus    wb;      // execute back to the register file

    operandIssue uIssue (
        .i_clk         (i_clk),
        .i_rstN        (i_rstN),
        .i_instrValid  (i_instrValid),
        .i_instr       (i_instr),
        .o_instrCredit (o_instrCredit),
        .o_push        (push),
        .o_packet      (packet),
        .i_queueCredit (queueCredit),
        .i_wb          (wb)
    );

    issueQueue uQueue (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_push     (push),
        .i_packet   (packet),
        .i_pop      (pop),
        .o_head     (head),
        .o_notEmpty (notEmpty),
        .o_credit   (queueCredit)
    );

    executeStage uExec (
        .i_clk       (i_clk),
        .i_rstN      (i_rstN),
        .i_head      (head),
        .i_notEmpty  (notEmpty),
        .o_pop       (pop),
        .o_resValid  (o_resValid),
        .o_result    (o_result),
        .i_resCredit (i_resCredit),
        .o_wb        (wb)
    );

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module executeStage
    import exPkg::*;
(
    input  logic    i_clk,
    input  logic    i_rstN,
    input  exPacket i_head,
    input  logic    i_notEmpty,
    output logic    o_pop,
    output logic    o_resValid,
    output exResult o_result,
    input  logic    i_resCredit,
    output wbBus    o_wb
);

    localparam int CntW = $clog2(`QUEUE_DEPTH + 1);

    logic [CntW-1:0] outCredits;   // free slots downstream of the result port
    dataWord         opB;
    dataWord         aluOut;
    exResult         res;
    logic            wbValid;
    regIdx           wbIdx;
    dataWord         wbData;

    assign o_pop = i_notEmpty && (outCredits != '0);

    always_comb begin
        opB = i_head.aluSrcB ? i_head.imm : i_head.dataB;
        case (i_head.aluOp)
            aluAdd:  aluOut = i_head.dataA + opB;
            aluSub:  aluOut = i_head.dataA - opB;
            aluAnd:  aluOut = i_head.dataA & opB;
            aluOr:   aluOut = i_head.dataA | opB;
            aluSlt:  aluOut = {{(`DATA_W-1){1'b0}}, $signed(i_head.dataA) < $signed(opB)};
            aluNor:  aluOut = ~(i_head.dataA | opB);
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        res.aluOut      = aluOut;
        res.zero        = (aluOut == '0);
        res.writeData   = i_head.dataB;  // register value even when the immediate was used
        res.writeReg    = i_head.regDst ? i_head.rd : i_head.rt;
        res.regWrite    = i_head.regWrite;
        res.memWrite    = i_head.memWrite;
        res.memToReg    = i_head.memToReg;
        res.branchReq   = i_head.branchReq;
        res.branchTaken = i_head.branchReq && res.zero;
        // word offset, the two low bits of the immediate are dropped
        res.branchAddr  = i_head.pcPlus4 + addrWord'({i_head.imm[`DATA_W-1:2], 2'b00});
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_result <= res;
            wbIdx    <= res.writeReg;
            wbData   <= res.aluOut;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_resValid <= 1'b0;
            wbValid    <= 1'b0;
        end else begin
            o_resValid <= o_pop;
            // loads would write back from memory, which is outside this slice
            wbValid    <= o_pop && res.regWrite && !res.memToReg && (res.writeReg != '0);
        end
    end

    assign o_wb.valid = wbValid;
    assign o_wb.idx   = wbIdx;
    assign o_wb.data  = wbData;

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            outCredits <= CntW'(`QUEUE_DEPTH);
        end else if (o_pop && !i_resCredit) begin
            outCredits <= outCredits - 1'b1;
        end else if (!o_pop && i_resCredit) begin
            outCredits <= outCredits + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/issueQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module issueQueue
    import exPkg::*;
#(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic    i_clk,
    input  logic    i_rstN,
    input  logic    i_push,
    input  exPacket i_packet,
    input  logic    i_pop,
    output exPacket o_head,
    output logic    o_notEmpty,
    output logic    o_credit
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    exPacket         mem [DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    assign o_head     = mem[rdPtr];
    assign o_notEmpty = (count != '0);

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wrPtr] <= i_packet;
        end
    end

    // the producer only pushes with a credit in hand, so there is no full check
    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (i_pop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (!i_push && i_pop) begin
                count <= count - 1'b1;
            end
            o_credit <= i_pop;  // one credit back per freed entry
        end
    end

endmodule

`default_nettype wire

/* src/operandIssue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module operandIssue
    import exPkg::*;
(
    input  logic        i_clk,
    input  logic        i_rstN,
    input  logic        i_instrValid,
    input  decodedInstr i_instr,
    output logic        o_instrCredit,
    output logic        o_push,
    output exPacket     o_packet,
    input  logic        i_queueCredit,
    input  wbBus        i_wb
);

    localparam int CntW = $clog2(`QUEUE_DEPTH + 1);

    decodedInstr          held;
    logic                 holdValid;
    dataWord              regFile [`NUM_REGS];
    logic [`NUM_REGS-1:0] busy;          // one bit per register with a result in flight
    logic [CntW-1:0]      queueCredits;
    regIdx                dest;
    logic                 writesReg;
    logic                 hazard;
    logic                 issue;

    assign dest = held.regDst ? held.rd : held.rt;

    // only these instructions come back on the writeback bus
    assign writesReg = held.regWrite && !held.memToReg && (dest != '0);

    assign hazard = busy[held.rs] || busy[held.rt] || busy[dest];
    assign issue  = holdValid && !hazard && (queueCredits != '0);

    assign o_instrCredit = issue;  // the slot is free again after this edge
    assign o_push        = issue;

    always_comb begin
        o_packet.dataA     = (held.rs == '0) ? '0 : regFile[held.rs];
        o_packet.dataB     = (held.rt == '0) ? '0 : regFile[held.rt];
        o_packet.rt        = held.rt;
        o_packet.rd        = held.rd;
        o_packet.imm       = held.imm;
        o_packet.pcPlus4   = held.pcPlus4;
        o_packet.aluOp     = held.aluOp;
        o_packet.aluSrcB   = held.aluSrcB;
        o_packet.regDst    = held.regDst;
        o_packet.regWrite  = held.regWrite;
        o_packet.memWrite  = held.memWrite;
        o_packet.memToReg  = held.memToReg;
        o_packet.branchReq = held.branchReq;
    end

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            holdValid <= 1'b0;
        end else if (i_instrValid) begin
            holdValid <= 1'b1;
        end else if (issue) begin
            holdValid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instrValid) begin
            held <= i_instr;
        end
    end

    // writeback and issue never hit the same bit, a busy destination stalls issue
    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            busy <= '0;
        end else begin
            if (i_wb.valid) begin
                busy[i_wb.idx] <= 1'b0;
            end
            if (issue && writesReg) begin
                busy[dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (i_wb.valid) begin
            regFile[i_wb.idx] <= i_wb.data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            queueCredits <= CntW'(`QUEUE_DEPTH);
        end else if (issue && !i_queueCredit) begin
            queueCredits <= queueCredits - 1'b1;
        end else if (!issue && i_queueCredit) begin
            queueCredits <= queueCredits + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/exPkg.sv */
`default_nettype none

`include "pipe_consts.svh"

package exPkg;

    typedef logic [$clog2(`NUM_REGS)-1:0] regIdx;
    typedef logic [`DATA_W-1:0]           dataWord;
    typedef logic [`ADDR_W-1:0]           addrWord;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluNor
    } aluOp;

    typedef struct packed {
        regIdx   rs;
        regIdx   rt;
        regIdx   rd;
        dataWord imm;        // already sign extended by decode
        addrWord pcPlus4;
        aluOp    aluOp;
        logic    aluSrcB;    // set selects the immediate as operand B
        logic    regDst;     // set selects rd, clear selects rt
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    branchReq;
    } decodedInstr;

    // instruction after operand read, rs is no longer needed
    typedef struct packed {
        dataWord dataA;
        dataWord dataB;
        regIdx   rt;
        regIdx   rd;
        dataWord imm;
        addrWord pcPlus4;
        aluOp    aluOp;
        logic    aluSrcB;
        logic    regDst;
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    branchReq;
    } exPacket;

    typedef struct packed {
        logic    valid;
        regIdx   idx;
        dataWord data;
    } wbBus;

    typedef struct packed {
        dataWord aluOut;
        logic    zero;
        dataWord writeData;  // store data for the memory stage
        regIdx   writeReg;
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    branchReq;
        logic    branchTaken;
        addrWord branchAddr;
    } exResult;

endpackage

`default_nettype wire

/* src/pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// datapath and address widths of the MIPS-style slice
`define DATA_W      32
`define ADDR_W      32

`define NUM_REGS    32  // register 0 is hardwired to zero

// queue entries, also the producer's credits at reset
`define QUEUE_DEPTH 4

`define IN_CREDITS  1   // instruction slots the external source may fill

`endif
